// ==== fpuPkg.sv ====
// Shared value types, opcodes, status codes and structs of the FP execute unit
// Modules import this package in their bodies and use scoped names in their ports
`default_nettype none

package fpuPkg;
	typedef logic [63:0] fpDouble;
	typedef logic [31:0] fpSingle;
	typedef logic [5:0] regId; // Id 0 means no write
	typedef logic [5:0] fpOpcode;
	typedef logic [3:0] fpIxt;

	localparam fpOpcode OpNop = 6'h00;
	localparam fpOpcode OpFpu3 = 6'h01;
	localparam fpOpcode OpFcmp = 6'h02;
	localparam fpOpcode OpFldcx = 6'h03;
	localparam fpOpcode OpFstcx = 6'h04;
	localparam fpOpcode OpFixs = 6'h05;

	// Opcode extensions, meaning depends on the opcode
	localparam fpIxt IxtAdd = 4'h0;
	localparam fpIxt IxtSub = 4'h1;
	localparam fpIxt IxtMul = 4'h2;
	localparam fpIxt IxtMov = 4'h4;
	localparam fpIxt IxtCmpEq = 4'h0;
	localparam fpIxt IxtCmpGt = 4'h1;
	localparam fpIxt IxtLdSingle = 4'h0;
	localparam fpIxt IxtLdRaw = 4'h1;
	localparam fpIxt IxtStSingle = 4'h0;
	localparam fpIxt IxtStRaw = 4'h1;
	localparam fpIxt IxtNeg = 4'h0;
	localparam fpIxt IxtAbs = 4'h1;

	typedef enum logic [1:0] {
		StatusReady = 2'b00,
		StatusOk = 2'b01,
		StatusHold = 2'b10
	} exStatus;

	typedef enum logic [1:0] {
		CondAlways = 2'b00,
		CondNever = 2'b01,
		CondTrue = 2'b10,
		CondFalse = 2'b11
	} condCode;

	typedef struct packed {
		condCode cond;
		fpOpcode opcode;
		fpIxt ixt;
		regId dest;
	} fpCommand;

	typedef struct packed {
		fpDouble rs;
		fpDouble rt;
		fpDouble gprIn;
	} fpOperands;

	typedef struct packed {
		fpDouble fprValue;
		fpDouble gprValue;
		regId destId;
		exStatus status;
		logic srT;
	} fpResult;

	typedef enum logic {
		CtrlIdle,
		CtrlWait
	} ctrlState;

	localparam int CmpLatency = 1; // Registered compare
endpackage

`default_nettype wire

// ==== fpuAdd.sv ====
// Pipelined double adder and subtracter, sum = a + b or a - b
// Truncating, denormals flush to zero; the result is valid Stages cycles after the inputs
`timescale 1ns/1ps
`default_nettype none

module fpuAdd #(
	parameter int Stages = 5
) (
	input wire clock,
	input wire reset,
	input wire fpuPkg::fpDouble a,
	input wire fpuPkg::fpDouble b,
	input wire subtract,
	output fpuPkg::fpDouble sum
);
	import fpuPkg::*;

	logic [10:0] expA;
	logic [10:0] expB;
	logic [52:0] manA;
	logic [52:0] manB;
	logic bigIsA;
	logic signBig;
	logic signSmall;
	logic [10:0] expBig;
	logic [10:0] expSmall;
	logic [10:0] expDiff;
	logic [56:0] manBig;
	logic [56:0] manSmall;
	logic [56:0] manAligned;
	logic [56:0] manSum;
	logic [5:0] lzc;
	logic [56:0] manNorm;
	logic signed [12:0] expNorm;
	fpDouble result;
	fpDouble chain [Stages];

	function automatic logic [5:0] leadingZeros(input logic [56:0] value);
		logic [5:0] count;
		logic found;
		count = 6'd0;
		found = 1'b0;
		for (int i = 56; i >= 0; i--) begin
			if (value[i]) begin
				found = 1'b1;
			end else if (!found) begin
				count = count + 6'd1;
			end
		end
		return count;
	endfunction

	always_comb begin
		expA = a[62:52];
		expB = b[62:52];
		manA = (expA == 11'd0) ? 53'd0 : {1'b1, a[51:0]}; // Denormal counts as zero
		manB = (expB == 11'd0) ? 53'd0 : {1'b1, b[51:0]};

		// Order by magnitude so the difference never goes negative
		bigIsA = {expA, manA} >= {expB, manB};
		signBig = bigIsA ? a[63] : (b[63] ^ subtract);
		signSmall = bigIsA ? (b[63] ^ subtract) : a[63];
		expBig = bigIsA ? expA : expB;
		expSmall = bigIsA ? expB : expA;
		manBig = {1'b0, bigIsA ? manA : manB, 3'b000}; // Carry bit and three guard bits
		manSmall = {1'b0, bigIsA ? manB : manA, 3'b000};

		expDiff = expBig - expSmall;
		manAligned = (expDiff > 11'd56) ? 57'd0 : manSmall >> expDiff;
		manSum = (signBig == signSmall) ? manBig + manAligned : manBig - manAligned;

		// Leading one ends up in bit 56, fraction below it
		lzc = leadingZeros(manSum);
		manNorm = manSum << lzc;
		expNorm = $signed({2'b00, expBig}) + 13'sd1 - $signed({7'd0, lzc});

		if (manSum == 57'd0 || expNorm <= 13'sd0) begin
			result = '0;
		end else begin
			result = {signBig, expNorm[10:0], manNorm[55:4]};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < Stages; i++) begin
				chain[i] <= '0;
			end
		end else begin
			chain[0] <= result;
			for (int i = 1; i < Stages; i++) begin
				chain[i] <= chain[i - 1];
			end
		end
	end

	assign sum = chain[Stages - 1];
endmodule

`default_nettype wire

// ==== fpuMul.sv ====
// Pipelined double multiplier that forms product = a * b
// Truncates and flushes denormals and underflow to signed zero
// The product appears Stages cycles after the inputs
`timescale 1ns/1ps
`default_nettype none

module fpuMul #(
	parameter int Stages = 5
) (
	input wire clock,
	input wire reset,
	input wire fpuPkg::fpDouble a,
	input wire fpuPkg::fpDouble b,
	output fpuPkg::fpDouble product
);
	import fpuPkg::*;

	logic [10:0] expA;
	logic [10:0] expB;
	logic [52:0] manA;
	logic [52:0] manB;
	logic signOut;
	logic [105:0] manProd;
	logic [51:0] fracOut;
	logic signed [12:0] expOut;
	fpDouble result;
	fpDouble chain [Stages];

	always_comb begin
		expA = a[62:52];
		expB = b[62:52];
		manA = {1'b1, a[51:0]};
		manB = {1'b1, b[51:0]};
		signOut = a[63] ^ b[63];
		manProd = 106'(manA) * 106'(manB);
		expOut = $signed({2'b00, expA}) + $signed({2'b00, expB}) - 13'sd1023;

		// Product of two 1.x mantissas stays below 4 and needs one shift at most
		if (manProd[105]) begin
			fracOut = manProd[104:53];
			expOut = expOut + 13'sd1;
		end else begin
			fracOut = manProd[103:52];
		end

		if (expA == 11'd0 || expB == 11'd0 || expOut <= 13'sd0) begin
			result = {signOut, 63'd0};
		end else begin
			result = {signOut, expOut[10:0], fracOut};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < Stages; i++) begin
				chain[i] <= '0;
			end
		end else begin
			chain[0] <= result;
			for (int i = 1; i < Stages; i++) begin
				chain[i] <= chain[i - 1];
			end
		end
	end

	assign product = chain[Stages - 1];
endmodule

`default_nettype wire

// ==== fpuCmp.sv ====
// Registered double compare, flag is a == b or a > b as selected by greater
// One cycle of latency; +0 and -0 compare equal
`timescale 1ns/1ps
`default_nettype none

module fpuCmp (
	input wire clock,
	input wire reset,
	input wire fpuPkg::fpDouble a,
	input wire fpuPkg::fpDouble b,
	input wire greater,
	output logic flag
);
	logic [62:0] magA;
	logic [62:0] magB;
	logic bothZero;
	logic isEqual;
	logic isGreater;

	always_comb begin
		magA = (a[62:52] == 11'd0) ? 63'd0 : a[62:0]; // Denormals are zero
		magB = (b[62:52] == 11'd0) ? 63'd0 : b[62:0];
		bothZero = (magA == 63'd0) && (magB == 63'd0);
		isEqual = bothZero || ((a[63] == b[63]) && (magA == magB));

		if (bothZero) begin
			isGreater = 1'b0;
		end else if (a[63] != b[63]) begin
			isGreater = !a[63]; // Positive beats negative
		end else if (!a[63]) begin
			isGreater = magA > magB;
		end else begin
			isGreater = magA < magB; // Both negative, order flips
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			flag <= 1'b0;
		end else begin
			flag <= greater ? isGreater : isEqual;
		end
	end
endmodule

`default_nettype wire

// ==== fpuConv.sv ====
// Combinational single to double widening and double to single narrowing
// Mantissa is truncated, zero and denormal inputs give signed zero
`timescale 1ns/1ps
`default_nettype none

module fpuConv (
	input wire fpuPkg::fpSingle singleIn,
	output fpuPkg::fpDouble doubleOut,
	input wire fpuPkg::fpDouble doubleIn,
	output fpuPkg::fpSingle singleOut
);
	logic [7:0] expSingle;
	logic [10:0] expWide;
	logic [10:0] expDouble;
	logic [10:0] expNarrow;

	// Single to double, bias moves from 127 to 1023
	always_comb begin
		expSingle = singleIn[30:23];
		expWide = {3'b000, expSingle} + 11'd896;
		if (expSingle == 8'd0) begin
			doubleOut = {singleIn[31], 63'd0};
		end else begin
			doubleOut = {singleIn[31], expWide, singleIn[22:0], 29'd0};
		end
	end

	// Double to single
	always_comb begin
		expDouble = doubleIn[62:52];
		expNarrow = expDouble - 11'd896;
		if (expDouble <= 11'd896) begin
			singleOut = {doubleIn[63], 31'd0}; // Too small for a normal single
		end else if (expDouble >= 11'd1151) begin
			singleOut = {doubleIn[63], 8'hFE, 23'h7FFFFF}; // Clamp to largest finite
		end else begin
			singleOut = {doubleIn[63], expNarrow[7:0], doubleIn[51:29]};
		end
	end
endmodule

`default_nettype wire

// ==== fpuHoldTimer.sv ====
// Counts held cycles for the execute control
// reached goes high once enable has been high for target cycles in a row
`timescale 1ns/1ps
`default_nettype none

module fpuHoldTimer (
	input wire clock,
	input wire reset,
	input wire enable,
	input wire [3:0] target,
	output logic reached
);
	logic [3:0] count;

	always_ff @(posedge clock) begin
		if (reset || !enable) begin
			count <= 4'd0; // Cleared between commands
		end else begin
			count <= count + 4'd1;
		end
	end

	assign reached = (count == target);
endmodule

`default_nettype wire

// ==== fpuExControl.sv ====
// Execute control: condition gating, HOLD sequencing and the result multiplexer
// Single-cycle ops answer combinationally, pipelined ops hold for a fixed count
`timescale 1ns/1ps
`default_nettype none

module fpuExControl #(
	parameter int AddStages = 5,
	parameter int MulStages = 5
) (
	input wire clock,
	input wire reset,
	input wire fpuPkg::fpCommand command,
	input wire fpuPkg::fpOperands operands,
	input wire srT,
	input wire flush,
	input wire fpuPkg::fpDouble sumIn,
	input wire fpuPkg::fpDouble productIn,
	input wire fpuPkg::fpDouble doubleIn,
	input wire fpuPkg::fpSingle singleIn,
	input wire cmpFlag,
	output logic subtract,
	output logic greater,
	output logic holdEnable,
	output logic [3:0] holdTarget,
	input wire reached,
	output fpuPkg::fpResult result
);
	import fpuPkg::*;

	ctrlState state;
	ctrlState stateNext;
	logic opEnable;
	fpOpcode opcode;
	logic opValid;
	logic multiCycle;
	logic done;

	// Operation selects go straight to the data units
	assign subtract = (command.ixt == IxtSub);
	assign greater = (command.ixt == IxtCmpGt);

	always_comb begin
		case (command.cond)
			CondAlways: opEnable = 1'b1;
			CondNever: opEnable = 1'b0;
			CondTrue: opEnable = srT;
			default: opEnable = !srT;
		endcase
		if (flush || reset) begin
			opEnable = 1'b0;
		end
		opcode = opEnable ? command.opcode : OpNop;
		done = (state == CtrlWait) && reached;

		opValid = 1'b0;
		multiCycle = 1'b0;
		holdTarget = 4'd0;
		result = '0;
		result.status = StatusReady;
		result.srT = srT; // Passes through unless a compare finishes

		case (opcode)
			OpFpu3: begin
				opValid = 1'b1;
				result.destId = command.dest;
				case (command.ixt)
					IxtAdd, IxtSub: begin
						multiCycle = 1'b1;
						holdTarget = 4'(AddStages);
						result.fprValue = sumIn;
					end
					IxtMul: begin
						multiCycle = 1'b1;
						holdTarget = 4'(MulStages);
						result.fprValue = productIn;
					end
					IxtMov: result.fprValue = operands.rs;
					default: result.destId = '0;
				endcase
				result.gprValue = result.fprValue;
			end
			OpFcmp: begin
				opValid = 1'b1;
				multiCycle = 1'b1;
				holdTarget = 4'(CmpLatency);
				if (done) begin
					result.srT = cmpFlag;
				end
			end
			OpFldcx: begin
				opValid = 1'b1;
				result.destId = command.dest;
				case (command.ixt)
					IxtLdSingle: result.fprValue = doubleIn;
					IxtLdRaw: result.fprValue = operands.gprIn;
					default: result.destId = '0;
				endcase
				result.gprValue = result.fprValue;
			end
			OpFstcx: begin
				opValid = 1'b1;
				case (command.ixt)
					IxtStSingle: result.gprValue = {32'd0, singleIn};
					IxtStRaw: result.gprValue = operands.rs;
					default: result.gprValue = '0;
				endcase
			end
			OpFixs: begin
				opValid = 1'b1;
				result.destId = command.dest;
				case (command.ixt)
					IxtNeg: result.fprValue = {~operands.rs[63], operands.rs[62:0]};
					IxtAbs: result.fprValue = {1'b0, operands.rs[62:0]};
					default: result.destId = '0;
				endcase
				result.gprValue = result.fprValue;
			end
			default: begin
			end
		endcase

		holdEnable = multiCycle && !done;
		if (holdEnable) begin
			result.status = StatusHold;
		end else if (opValid) begin
			result.status = StatusOk;
		end
	end

	// Idle until a pipelined op starts, wait until the timer says it is through
	always_comb begin
		stateNext = state;
		case (state)
			CtrlIdle: begin
				if (multiCycle) begin
					stateNext = CtrlWait;
				end
			end
			CtrlWait: begin
				if (reached || flush || !multiCycle) begin
					stateNext = CtrlIdle;
				end
			end
			default: stateNext = CtrlIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CtrlIdle;
		end else begin
			state <= stateNext;
		end
	end
endmodule

`default_nettype wire

// ==== fpuExUnit.sv ====
// Top of the FP execute unit, a slave to the main execute stage
// Upstream keeps command and operands stable while result.status is HOLD
`timescale 1ns/1ps
`default_nettype none

module fpuExUnit #(
	parameter int AddStages = 5,
	parameter int MulStages = 5
) (
	input wire clock,
	input wire reset,
	input wire fpuPkg::fpCommand command,
	input wire fpuPkg::fpOperands operands,
	input wire srT,
	input wire flush,
	output fpuPkg::fpResult result
);
	import fpuPkg::*;

	fpDouble sum;
	fpDouble product;
	fpDouble widened;
	fpSingle narrowed;
	logic cmpFlag;
	logic subtract;
	logic greater;
	logic holdEnable;
	logic [3:0] holdTarget;
	logic reached;

	// Data units see the operands directly, rs op rt
	fpuAdd #(
		.Stages(AddStages)
	) adder (
		.clock(clock),
		.reset(reset),
		.a(operands.rs),
		.b(operands.rt),
		.subtract(subtract),
		.sum(sum)
	);

	fpuMul #(
		.Stages(MulStages)
	) multiplier (
		.clock(clock),
		.reset(reset),
		.a(operands.rs),
		.b(operands.rt),
		.product(product)
	);

	fpuCmp comparator (
		.clock(clock),
		.reset(reset),
		.a(operands.rs),
		.b(operands.rt),
		.greater(greater),
		.flag(cmpFlag)
	);

	fpuConv converter (
		.singleIn(operands.gprIn[31:0]), // Single lives in the low GPR half
		.doubleOut(widened),
		.doubleIn(operands.rs),
		.singleOut(narrowed)
	);

	fpuHoldTimer holdTimer (
		.clock(clock),
		.reset(reset),
		.enable(holdEnable),
		.target(holdTarget),
		.reached(reached)
	);

	fpuExControl #(
		.AddStages(AddStages),
		.MulStages(MulStages)
	) control (
		.clock(clock),
		.reset(reset),
		.command(command),
		.operands(operands),
		.srT(srT),
		.flush(flush),
		.sumIn(sum),
		.productIn(product),
		.doubleIn(widened),
		.singleIn(narrowed),
		.cmpFlag(cmpFlag),
		.subtract(subtract),
		.greater(greater),
		.holdEnable(holdEnable),
		.holdTarget(holdTarget),
		.reached(reached),
		.result(result)
	);
endmodule

`default_nettype wire

// ==== fpuExUnit_tb.sv ====
// Testbench for the FP execute unit, checked against a real-arithmetic reference model
// Directed tests per operation, a flush case, then seeded random commands
`timescale 1ns/1ps
`default_nettype none

module fpuExUnit_tb;
	import fpuPkg::*;

	localparam int AddStages = 5;
	localparam int MulStages = 5;
	localparam int CmpHolds = 1;
	localparam int RandomCount = 150;
	localparam int MaxCycles = 4000; // ~190 commands of at most 6 cycles, with wide margin
	localparam fpDouble NegZero = 64'h8000_0000_0000_0000;

	logic clock;
	logic reset;
	fpCommand command;
	fpOperands operands;
	logic srT;
	logic flush;
	fpResult result;

	integer seed;
	int errors;
	int checks;
	int cycles;
	fpResult wantQ[$];
	fpResult gotQ[$];
	int wantHoldQ[$];
	int gotHoldQ[$];

	fpuExUnit #(
		.AddStages(AddStages),
		.MulStages(MulStages)
	) DUT (
		.clock(clock),
		.reset(reset),
		.command(command),
		.operands(operands),
		.srT(srT),
		.flush(flush),
		.result(result)
	);

	always #20 clock = ~clock;

	function automatic real pow2(input int e);
		real p;
		p = 1.0;
		for (int i = 0; i < e; i++) begin
			p = p * 2.0;
		end
		for (int i = 0; i < -e; i++) begin
			p = p / 2.0;
		end
		return p;
	endfunction

	// IEEE single decode, normals only
	function automatic real singleToReal(input logic [31:0] s);
		real mag;
		if (s[30:23] == 8'd0) begin
			mag = 0.0;
		end else begin
			mag = (1.0 + real'(s[22:0]) / 8388608.0) * pow2(int'(s[30:23]) - 127);
		end
		return s[31] ? -mag : mag;
	endfunction

	function automatic logic [31:0] realToSingle(input real v);
		real mag;
		int e;
		logic sign;
		sign = v < 0.0;
		mag = sign ? -v : v;
		e = 0;
		if (mag == 0.0) begin
			return {sign, 31'd0};
		end
		while (mag >= 2.0) begin
			mag = mag / 2.0;
			e++;
		end
		while (mag < 1.0) begin
			mag = mag * 2.0;
			e--;
		end
		return {sign, 8'(e + 127), 23'($rtoi((mag - 1.0) * 8388608.0))};
	endfunction

	function automatic logic conditionHolds(input condCode cond, input logic tIn);
		case (cond)
			CondAlways: return 1'b1;
			CondNever: return 1'b0;
			CondTrue: return tIn;
			default: return !tIn;
		endcase
	endfunction

	// Reference model for one command
	function automatic fpResult expectedResult(input fpCommand cmd, input fpOperands ops,
			input logic tIn);
		fpResult r;
		real a;
		real b;
		a = $bitstoreal(ops.rs);
		b = $bitstoreal(ops.rt);
		r = '0;
		r.status = StatusReady;
		r.srT = tIn;
		if (!conditionHolds(cmd.cond, tIn) || cmd.opcode == OpNop) begin
			return r;
		end
		r.status = StatusOk;
		case (cmd.opcode)
			OpFpu3: begin
				r.destId = cmd.dest;
				if (cmd.ixt == IxtAdd) begin
					r.fprValue = $realtobits(a + b);
				end else if (cmd.ixt == IxtSub) begin
					r.fprValue = $realtobits(a - b);
				end else if (cmd.ixt == IxtMul) begin
					r.fprValue = $realtobits(a * b);
				end else begin
					r.fprValue = ops.rs;
				end
				r.gprValue = r.fprValue;
			end
			OpFcmp: r.srT = (cmd.ixt == IxtCmpGt) ? (a > b) : (a == b);
			OpFldcx: begin
				r.destId = cmd.dest;
				if (cmd.ixt == IxtLdSingle) begin
					r.fprValue = $realtobits(singleToReal(ops.gprIn[31:0]));
				end else begin
					r.fprValue = ops.gprIn;
				end
				r.gprValue = r.fprValue;
			end
			OpFstcx: begin
				if (cmd.ixt == IxtStSingle) begin
					r.gprValue = {32'd0, realToSingle(a)};
				end else begin
					r.gprValue = ops.rs;
				end
			end
			default: begin
				r.destId = cmd.dest;
				r.fprValue = $realtobits((cmd.ixt == IxtNeg || a < 0.0) ? -a : a);
				r.gprValue = r.fprValue;
			end
		endcase
		return r;
	endfunction

	function automatic int holdCycles(input fpCommand cmd, input logic tIn);
		if (!conditionHolds(cmd.cond, tIn)) begin
			return 0;
		end
		if (cmd.opcode == OpFpu3 && (cmd.ixt == IxtAdd || cmd.ixt == IxtSub)) begin
			return AddStages;
		end
		if (cmd.opcode == OpFpu3 && cmd.ixt == IxtMul) begin
			return MulStages;
		end
		return (cmd.opcode == OpFcmp) ? CmpHolds : 0;
	endfunction

	function automatic fpCommand makeCommand(input condCode cond, input fpOpcode opcode,
			input fpIxt ixt, input regId dest);
		fpCommand c;
		c.cond = cond;
		c.opcode = opcode;
		c.ixt = ixt;
		c.dest = dest;
		return c;
	endfunction

	function automatic fpOperands bitOperands(input fpDouble rs, input fpDouble rt,
			input fpDouble gpr);
		fpOperands o;
		o.rs = rs;
		o.rt = rt;
		o.gprIn = gpr;
		return o;
	endfunction

	function automatic fpOperands realOperands(input real rs, input real rt);
		return bitOperands($realtobits(rs), $realtobits(rt), 64'd0);
	endfunction

	// Small integer times a power of two, so every result is exact
	function automatic fpDouble randomValue();
		int mag;
		int shift;
		real v;
		mag = 1 + int'({$random(seed)} % 15);
		shift = int'({$random(seed)} % 9) - 4;
		v = real'(mag) * pow2(shift);
		if ($random(seed) & 1) begin
			v = -v;
		end
		return $realtobits(v);
	endfunction

	function automatic condCode randomCond();
		if ({$random(seed)} % 4 != 0) begin
			return CondAlways;
		end
		return condCode'(2'($random(seed)));
	endfunction

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Applies one command and keeps it stable through HOLD
	task automatic runCommand(input fpCommand cmd, input fpOperands ops, input logic tIn);
		fpResult want;
		int holds;
		want = expectedResult(cmd, ops, tIn);
		holds = 0;
		@(posedge clock);
		command <= cmd;
		operands <= ops;
		srT <= tIn;
		flush <= 1'b0;
		@(negedge clock);
		while (result.status == StatusHold) begin
			holds++;
			@(negedge clock);
		end
		wantQ.push_back(want);
		gotQ.push_back(result);
		wantHoldQ.push_back(holdCycles(cmd, tIn));
		gotHoldQ.push_back(holds);
	endtask

	// Add that is flushed after two HOLD cycles
	task automatic flushDuringAdd(input fpOperands ops, input logic tIn);
		fpResult want;
		int holds;
		want = '0;
		want.status = StatusReady;
		want.srT = tIn;
		holds = 0;
		@(posedge clock);
		command <= makeCommand(CondAlways, OpFpu3, IxtAdd, 6'd12);
		operands <= ops;
		srT <= tIn;
		flush <= 1'b0;
		repeat (2) begin
			@(negedge clock);
			if (result.status == StatusHold) begin
				holds++;
			end
		end
		@(posedge clock);
		flush <= 1'b1;
		@(negedge clock);
		wantQ.push_back(want);
		gotQ.push_back(result);
		wantHoldQ.push_back(2);
		gotHoldQ.push_back(holds);
	endtask

	always @(posedge clock) begin
		fpResult want;
		fpResult got;
		while (gotQ.size() > 0) begin
			got = gotQ.pop_front();
			want = wantQ.pop_front();
			checkValue("result.status", 64'(got.status), 64'(want.status));
			checkValue("result.destId", 64'(got.destId), 64'(want.destId));
			checkValue("result.fprValue", got.fprValue, want.fprValue);
			checkValue("result.gprValue", got.gprValue, want.gprValue);
			checkValue("result.srT", 64'(got.srT), 64'(want.srT));
			checkValue("hold cycles", 64'(gotHoldQ.pop_front()), 64'(wantHoldQ.pop_front()));
		end
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		fpCommand cmd;
		fpDouble rsBits;
		fpDouble rtBits;
		fpIxt ixt;
		fpOpcode opcode;
		int sel;
		clock = 1'b0;
		reset = 1'b1;
		command = '0;
		operands = '0;
		srT = 1'b0;
		flush = 1'b0;
		seed = 28580;
		errors = 0;
		checks = 0;
		cycles = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		runCommand(makeCommand(CondAlways, OpFpu3, IxtAdd, 6'd1), realOperands(3.0, 1.5), 1'b0);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtSub, 6'd2), realOperands(3.0, 5.25), 1'b1);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtMul, 6'd3), realOperands(-2.5, 4.0), 1'b0);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtAdd, 6'd4), realOperands(-0.75, 0.75), 1'b0);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtMul, 6'd5), realOperands(0.125, 24.0), 1'b1);

		// Compare, srT starts opposite to the answer
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpEq, 6'd0), realOperands(2.0, 2.0), 1'b0);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpEq, 6'd0), realOperands(2.0, 3.0), 1'b1);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpEq, 6'd0), bitOperands(64'd0, NegZero, 64'd0),
			1'b0);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpGt, 6'd0), realOperands(3.0, 2.0), 1'b0);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpGt, 6'd0), realOperands(2.0, 3.0), 1'b1);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpGt, 6'd0), bitOperands(64'd0, NegZero, 64'd0),
			1'b1);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpGt, 6'd0), bitOperands(NegZero, 64'd0, 64'd0),
			1'b1);
		runCommand(makeCommand(CondAlways, OpFcmp, IxtCmpGt, 6'd0), realOperands(-1.0, -2.0), 1'b0);

		runCommand(makeCommand(CondAlways, OpFixs, IxtNeg, 6'd7), realOperands(5.5, 1.0), 1'b1);
		runCommand(makeCommand(CondAlways, OpFixs, IxtAbs, 6'd8), realOperands(-12.0, 1.0), 1'b0);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtMov, 6'd63), realOperands(0.3125, 9.0), 1'b1);

		// Loads read gprIn, upper half ignored for the single form
		runCommand(makeCommand(CondAlways, OpFldcx, IxtLdSingle, 6'd9),
			bitOperands(64'd0, 64'd0, 64'h0000_0000_3FC0_0000), 1'b0);
		runCommand(makeCommand(CondAlways, OpFldcx, IxtLdSingle, 6'd10),
			bitOperands(64'd0, 64'd0, 64'hFFFF_FFFF_C120_0000), 1'b0);
		runCommand(makeCommand(CondAlways, OpFldcx, IxtLdRaw, 6'd11),
			bitOperands(64'd0, 64'd0, $realtobits(-7.75)), 1'b1);
		runCommand(makeCommand(CondAlways, OpFstcx, IxtStSingle, 6'd13), realOperands(6.25, 0.0), 1'b0);
		runCommand(makeCommand(CondAlways, OpFstcx, IxtStSingle, 6'd14), realOperands(-0.046875, 0.0),
			1'b0);
		runCommand(makeCommand(CondAlways, OpFstcx, IxtStRaw, 6'd15), realOperands(123.5, 0.0), 1'b1);

		// Condition gating
		runCommand(makeCommand(CondNever, OpFpu3, IxtAdd, 6'd16), realOperands(1.0, 2.0), 1'b0);
		runCommand(makeCommand(CondTrue, OpFpu3, IxtAdd, 6'd17), realOperands(1.0, 2.0), 1'b0);
		runCommand(makeCommand(CondFalse, OpFpu3, IxtMul, 6'd18), realOperands(1.0, 2.0), 1'b1);
		runCommand(makeCommand(CondTrue, OpFixs, IxtNeg, 6'd19), realOperands(4.0, 0.0), 1'b1);
		runCommand(makeCommand(CondFalse, OpFpu3, IxtSub, 6'd20), realOperands(8.0, 0.5), 1'b0);
		runCommand(makeCommand(CondNever, OpFcmp, IxtCmpEq, 6'd0), realOperands(1.0, 1.0), 1'b0);

		flushDuringAdd(realOperands(9.0, 2.5), 1'b1);
		runCommand(makeCommand(CondAlways, OpFpu3, IxtAdd, 6'd21), realOperands(9.0, 2.5), 1'b1);

		for (int n = 0; n < RandomCount; n++) begin
			sel = int'({$random(seed)} % 7);
			opcode = (sel < 3) ? OpFpu3 : (sel < 5) ? OpFcmp : (sel == 5) ? OpFixs : OpFstcx;
			ixt = (sel < 3) ? fpIxt'(sel) : (sel == 4) ? IxtCmpGt : IxtCmpEq;
			cmd = makeCommand(randomCond(), opcode, ixt, 6'(1 + {$random(seed)} % 63));
			rsBits = randomValue();
			rtBits = randomValue();
			runCommand(cmd, bitOperands(rsBits, rtBits, 64'd0), 1'($random(seed)));
		end

		repeat (2) @(posedge clock);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

// ==== verilog.f ====
fpuPkg.sv
fpuAdd.sv
fpuMul.sv
fpuCmp.sv
fpuConv.sv
fpuHoldTimer.sv
fpuExControl.sv
fpuExUnit.sv
fpuExUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module fpuExUnit_tb -f verilog.f -o simv
./obj_dir/simv > sim.log
cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
